/* verilog/wb_harness_pkg.sv */
package wb_harness_pkg;

    // Bus widths shared by the bridges, the arbiter and the top level
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8; // One enable per byte lane

    // Full byte mask, used for instruction fetches
    localparam logic [SEL_W-1:0] SEL_ALL = '1;

    // One bus request as the core presents it
    // Field order from MSB: address, write flag, byte enables, write data
    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic              we;    // 1 = write, 0 = read
        logic [SEL_W-1:0]  sel;
        logic [DATA_W-1:0] dat_w;
    } bus_req_t;

    // Which master currently holds the shared port
    typedef enum logic {
        OWNER_INSTR = 1'b0,
        OWNER_DATA  = 1'b1
    } owner_e;

    // The other master, used for the round-robin tie break
    function automatic owner_e other_owner(input owner_e owner);
        owner_e result;
        if (owner == OWNER_INSTR) begin
            result = OWNER_DATA;
        end else begin
            result = OWNER_INSTR;
        end
        return result;
    endfunction

endpackage

/* verilog/wb_bus_if.sv */
interface wb_bus_if import wb_harness_pkg::*;;

    logic              cyc;   // Transaction open
    logic              stb;   // Strobe, tied to cyc
    logic              we;
    logic [SEL_W-1:0]  sel;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat_w; // Master to slave
    logic [DATA_W-1:0] dat_r; // Slave to master
    logic              ack;   // One-cycle pulse

    modport master (
        output cyc,
        output stb,
        output we,
        output sel,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  sel,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

/* verilog/core_port_bridge.sv */
module core_port_bridge import wb_harness_pkg::*; (
    input  logic              clk_core,
    input  logic              rst_i,

    // Core side, req/gnt/rvalid
    input  logic              req_i,
    input  bus_req_t          req_data_i,
    output logic              gnt_o,
    output logic              rvalid_o,
    output logic [DATA_W-1:0] rdata_o,

    // Wishbone classic master
    wb_bus_if.master          bus
);

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_BUSY = 1'b1
    } state_e;

    state_e            state_q;
    bus_req_t          req_q;   // Request held for the whole bus cycle
    logic              ack_q;   // Registered ack, doubles as gnt/rvalid
    logic [DATA_W-1:0] rdata_q;
    logic              take_req;

    // The core still holds req_i in the gnt cycle, so that cycle is skipped
    assign take_req = (state_q == ST_IDLE) && req_i && !ack_q;

    always_ff @(posedge clk_core) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= (state_q == ST_BUSY) && bus.ack;
            case (state_q)
                ST_IDLE: begin
                    if (take_req) begin
                        state_q <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (bus.ack) begin
                        state_q <= ST_IDLE; // Drops cyc in the cycle after ack
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk_core) begin
        if (take_req) begin
            req_q <= req_data_i;
        end
        if ((state_q == ST_BUSY) && bus.ack) begin
            rdata_q <= bus.dat_r;
        end
    end

    // Bus fields come only from the captured request
    assign bus.cyc   = (state_q == ST_BUSY);
    assign bus.stb   = bus.cyc;
    assign bus.we    = req_q.we;
    assign bus.sel   = req_q.sel;
    assign bus.adr   = req_q.adr;
    assign bus.dat_w = req_q.dat_w;

    // Response to the core, one cycle after the bus ack
    assign gnt_o    = ack_q;
    assign rvalid_o = ack_q;
    assign rdata_o  = rdata_q;

    // A waiting core keeps its request steady until gnt
    a_hold_while_wait : assert property (
        @(posedge clk_core) disable iff (rst_i)
        req_i && !gnt_o |=> req_i && $stable(req_data_i)
    ) else $error("core dropped or changed its request before gnt");

endmodule

/* verilog/wb_rr_arbiter.sv */
module wb_rr_arbiter import wb_harness_pkg::*; (
    input  logic              clk_core,
    input  logic              rst_i,

    // Two Wishbone masters, seen from the slave side
    wb_bus_if.slave           m_instr,
    wb_bus_if.slave           m_data,

    // Shared memory port
    output logic              mem_cyc_o,
    output logic              mem_stb_o,
    output logic              mem_we_o,
    output logic [SEL_W-1:0]  mem_sel_o,
    output logic [ADDR_W-1:0] mem_adr_o,
    output logic [DATA_W-1:0] mem_dat_o,
    input  logic [DATA_W-1:0] mem_dat_i,
    input  logic              mem_ack_i
);

    owner_e owner_q;    // Current owner while locked, last served otherwise
    logic   lock_q;     // Transaction open and not yet acked
    owner_e next_owner;
    owner_e sel_owner;
    logic   any_req;

    assign any_req = m_instr.cyc || m_data.cyc;

    // Round robin pick, the master not served last wins a tie
    always_comb begin
        if (m_instr.cyc && m_data.cyc) begin
            next_owner = other_owner(owner_q);
        end else if (m_data.cyc) begin
            next_owner = OWNER_DATA;
        end else if (m_instr.cyc) begin
            next_owner = OWNER_INSTR;
        end else begin
            next_owner = owner_q;
        end
    end

    // Open transaction keeps its owner, otherwise the pick goes straight through
    assign sel_owner = lock_q ? owner_q : next_owner;

    always_ff @(posedge clk_core) begin
        if (rst_i) begin
            owner_q <= OWNER_DATA; // Instruction wins the first tie
            lock_q  <= 1'b0;
        end else if (!lock_q) begin
            if (any_req) begin
                owner_q <= next_owner;
                lock_q  <= !mem_ack_i; // No lock needed for a zero-wait ack
            end
        end else if (mem_ack_i) begin
            lock_q <= 1'b0;
        end
    end

    // Owner fields onto the shared port
    always_comb begin
        if (sel_owner == OWNER_INSTR) begin
            mem_cyc_o = m_instr.cyc;
            mem_stb_o = m_instr.stb;
            mem_we_o  = m_instr.we;
            mem_sel_o = m_instr.sel;
            mem_adr_o = m_instr.adr;
            mem_dat_o = m_instr.dat_w;
        end else begin
            mem_cyc_o = m_data.cyc;
            mem_stb_o = m_data.stb;
            mem_we_o  = m_data.we;
            mem_sel_o = m_data.sel;
            mem_adr_o = m_data.adr;
            mem_dat_o = m_data.dat_w;
        end
    end

    // Response goes back to the owner only
    always_comb begin
        m_instr.ack   = 1'b0;
        m_instr.dat_r = '0;
        m_data.ack    = 1'b0;
        m_data.dat_r  = '0;
        if (sel_owner == OWNER_INSTR) begin
            m_instr.ack   = mem_ack_i;
            m_instr.dat_r = mem_dat_i;
        end else begin
            m_data.ack    = mem_ack_i;
            m_data.dat_r  = mem_dat_i;
        end
    end

    // Memory must not ack an idle bus, and the ack must land on a live master
    a_ack_to_active : assert property (
        @(posedge clk_core) disable iff (rst_i)
        (m_instr.ack |-> m_instr.cyc) and (m_data.ack |-> m_data.cyc)
    ) else $error("ack routed to a master without cyc");

    // Shared port stays with its owner until the ack
    a_owner_locked : assert property (
        @(posedge clk_core) disable iff (rst_i)
        mem_cyc_o && !mem_ack_i |=> mem_cyc_o && $stable(mem_adr_o) && $stable(mem_we_o)
    ) else $error("owner changed during an open transaction");

endmodule

/* verilog/mem_harness_top.sv */
module mem_harness_top import wb_harness_pkg::*; (
    input  logic              clk_core,
    input  logic              rst_i,

    // Instruction port, read only
    input  logic              instr_req_i,
    input  logic [ADDR_W-1:0] instr_addr_i,
    output logic              instr_gnt_o,
    output logic              instr_rvalid_o,
    output logic [DATA_W-1:0] instr_rdata_o,

    // Data port
    input  logic              data_req_i,
    input  logic              data_we_i,
    input  logic [SEL_W-1:0]  data_be_i,
    input  logic [ADDR_W-1:0] data_addr_i,
    input  logic [DATA_W-1:0] data_wdata_i,
    output logic              data_gnt_o,
    output logic              data_rvalid_o,
    output logic [DATA_W-1:0] data_rdata_o,

    // Shared Wishbone memory port
    output logic              mem_cyc_o,
    output logic              mem_stb_o,
    output logic              mem_we_o,
    output logic [SEL_W-1:0]  mem_sel_o,
    output logic [ADDR_W-1:0] mem_adr_o,
    output logic [DATA_W-1:0] mem_dat_o,
    input  logic [DATA_W-1:0] mem_dat_i,
    input  logic              mem_ack_i
);

    bus_req_t instr_req;
    bus_req_t data_req;

    wb_bus_if instr_bus ();
    wb_bus_if data_bus ();

    // Fetches never write and always use all lanes
    assign instr_req.adr   = instr_addr_i;
    assign instr_req.we    = 1'b0;
    assign instr_req.sel   = SEL_ALL;
    assign instr_req.dat_w = '0;

    assign data_req.adr   = data_addr_i;
    assign data_req.we    = data_we_i;
    assign data_req.sel   = data_be_i;
    assign data_req.dat_w = data_wdata_i;

    core_port_bridge u_instr_bridge (
        .clk_core   (clk_core),
        .rst_i      (rst_i),
        .req_i      (instr_req_i),
        .req_data_i (instr_req),
        .gnt_o      (instr_gnt_o),
        .rvalid_o   (instr_rvalid_o),
        .rdata_o    (instr_rdata_o),
        .bus        (instr_bus.master)
    );

    core_port_bridge u_data_bridge (
        .clk_core   (clk_core),
        .rst_i      (rst_i),
        .req_i      (data_req_i),
        .req_data_i (data_req),
        .gnt_o      (data_gnt_o),
        .rvalid_o   (data_rvalid_o),
        .rdata_o    (data_rdata_o),
        .bus        (data_bus.master)
    );

    wb_rr_arbiter u_arbiter (
        .clk_core  (clk_core),
        .rst_i     (rst_i),
        .m_instr   (instr_bus.slave),
        .m_data    (data_bus.slave),
        .mem_cyc_o (mem_cyc_o),
        .mem_stb_o (mem_stb_o),
        .mem_we_o  (mem_we_o),
        .mem_sel_o (mem_sel_o),
        .mem_adr_o (mem_adr_o),
        .mem_dat_o (mem_dat_o),
        .mem_dat_i (mem_dat_i),
        .mem_ack_i (mem_ack_i)
    );

endmodule

/* testbench/tb_wb_memory.sv */
module tb_wb_memory import wb_harness_pkg::*; #(
    parameter logic [DATA_W-1:0] FILL_PATTERN = 32'h0
) (
    input  logic              clk_core,
    input  logic              rst_i,
    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [SEL_W-1:0]  sel_i,
    input  logic [ADDR_W-1:0] adr_i,
    input  logic [DATA_W-1:0] dat_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS = 256;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [7:0]        idx;          // Word index inside the model
    logic [DATA_W-1:0] lane_mask;
    logic [1:0]        wait_cnt;
    logic [1:0]        wait_target;  // Wait states for the current cycle
    int                seed = 8;
    int                rnd;

    assign idx       = adr_i[9:2];
    assign lane_mask = {{8{sel_i[3]}}, {8{sel_i[2]}}, {8{sel_i[1]}}, {8{sel_i[0]}}};
    assign dat_o     = mem[idx];

    // Ack as soon as the chosen number of wait states has passed
    assign ack_o = cyc_i && stb_i && (wait_cnt == wait_target);

    always @(posedge clk_core) begin
        if (rst_i) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= DATA_W'(i) ^ FILL_PATTERN; // Unwritten words
            end
            wait_cnt    <= 2'd0;
            rnd         = $random(seed);
            wait_target <= rnd[1:0];
        end else if (cyc_i && stb_i) begin
            if (ack_o) begin
                if (we_i) begin
                    mem[idx] <= (mem[idx] & ~lane_mask) | (dat_i & lane_mask);
                end
                wait_cnt    <= 2'd0;
                rnd         = $random(seed);
                wait_target <= rnd[1:0]; // New draw for the next cycle
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end
    end

endmodule

/* testbench/tb_mem_harness.sv */
module tb_mem_harness import wb_harness_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [DATA_W-1:0] FILL_PATTERN = 32'h5A3C_96E1;
    localparam int MEM_WORDS      = 256;
    localparam int INSTR_WORDS    = 128; // Fetches stay below, data lives above
    localparam logic [ADDR_W-1:0] DATA_BASE = ADDR_W'(INSTR_WORDS * 4);
    localparam int N_TIE          = 4;
    localparam int N_DIRECTED     = 4 + 4 + 2 * N_TIE + (N_TIE - 1);
    localparam int N_RAND_INSTR   = 80;
    localparam int N_RAND_DATA    = 120;
    localparam int N_TRANS        = N_DIRECTED + N_RAND_INSTR + N_RAND_DATA;
    localparam int TIMEOUT_CYCLES = 20 * N_TRANS + 100;

    typedef struct packed {
        logic              is_read;
        logic [DATA_W-1:0] word;
    } expect_t;

    logic              clk_core = 1'b0;
    logic              rst_i;
    logic              instr_req_i;
    logic [ADDR_W-1:0] instr_addr_i;
    logic              instr_gnt_o;
    logic              instr_rvalid_o;
    logic [DATA_W-1:0] instr_rdata_o;
    logic              data_req_i;
    logic              data_we_i;
    logic [SEL_W-1:0]  data_be_i;
    logic [ADDR_W-1:0] data_addr_i;
    logic [DATA_W-1:0] data_wdata_i;
    logic              data_gnt_o;
    logic              data_rvalid_o;
    logic [DATA_W-1:0] data_rdata_o;
    logic              mem_cyc_o;
    logic              mem_stb_o;
    logic              mem_we_o;
    logic [SEL_W-1:0]  mem_sel_o;
    logic [ADDR_W-1:0] mem_adr_o;
    logic [DATA_W-1:0] mem_dat_o;
    logic [DATA_W-1:0] mem_dat_i;
    logic              mem_ack_i;

    logic [DATA_W-1:0] shadow [MEM_WORDS];
    logic              shadow_written [MEM_WORDS];
    logic [DATA_W-1:0] instr_exp_q [$];
    expect_t           data_exp_q [$];
    owner_e            order_q [$];  // Ports in the order they completed
    owner_e            last_served;
    owner_e            winner;
    int                instr_issued = 0;
    int                instr_done = 0;
    int                data_issued = 0;
    int                data_done = 0;
    int                cycle_cnt = 0;
    int                seed = 8;

    mem_harness_top mem_harness_top_i (.*);

    tb_wb_memory #(.FILL_PATTERN(FILL_PATTERN)) u_memory (
        .clk_core (clk_core),
        .rst_i    (rst_i),
        .cyc_i    (mem_cyc_o),
        .stb_i    (mem_stb_o),
        .we_i     (mem_we_o),
        .sel_i    (mem_sel_o),
        .adr_i    (mem_adr_o),
        .dat_i    (mem_dat_o),
        .dat_o    (mem_dat_i),
        .ack_o    (mem_ack_i)
    );

    always #5 clk_core = ~clk_core;

    task automatic stop_on_failure();
        $display("test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp_val,
                              input logic [DATA_W-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
            stop_on_failure();
        end
    endtask

    task automatic check_owner(input string name, input owner_e exp_val, input owner_e act_val);
        if (act_val !== exp_val) begin
            $display("Fail at %0t: %s expected %s, got %s", $time, name,
                     exp_val.name(), act_val.name());
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp_val, act_val);
            stop_on_failure();
        end
    endtask

    task automatic check_sel(input string name, input logic [SEL_W-1:0] exp_val,
                             input logic [SEL_W-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp_val, act_val);
            stop_on_failure();
        end
    endtask

    function automatic logic [ADDR_W-1:0] word_addr(input int word);
        return ADDR_W'(word) << 2;
    endfunction

    // Reference memory, fill pattern unless a write has landed
    function automatic logic [DATA_W-1:0] expect_word(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] word;
        if (shadow_written[addr[9:2]]) begin
            word = shadow[addr[9:2]];
        end else begin
            word = (addr >> 2) ^ FILL_PATTERN;
        end
        return word;
    endfunction

    function automatic void record_write(input logic [ADDR_W-1:0] addr,
                                         input logic [SEL_W-1:0] be,
                                         input logic [DATA_W-1:0] wdata);
        logic [DATA_W-1:0] word;
        word = expect_word(addr);
        for (int b = 0; b < SEL_W; b++) begin
            if (be[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        shadow[addr[9:2]]         = word;
        shadow_written[addr[9:2]] = 1'b1;
    endfunction

    task automatic drive_slot();
        @(posedge clk_core);
        #1;
    endtask

    task automatic fetch(input logic [ADDR_W-1:0] addr);
        instr_req_i  = 1'b1;
        instr_addr_i = addr;
        instr_exp_q.push_back(expect_word(addr));
        instr_issued++;
        do begin
            @(negedge clk_core);
        end while (!instr_gnt_o);
        check_flag("instr_rvalid_o", 1'b1, instr_rvalid_o); // Same cycle as gnt
        drive_slot();
        instr_req_i = 1'b0;
    endtask

    task automatic data_access(input logic we, input logic [SEL_W-1:0] be,
                               input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        expect_t exp;
        data_req_i   = 1'b1;
        data_we_i    = we;
        data_be_i    = be;
        data_addr_i  = addr;
        data_wdata_i = wdata;
        exp.is_read  = !we;
        exp.word     = we ? '0 : expect_word(addr);
        if (we) begin
            record_write(addr, be, wdata);
        end
        data_exp_q.push_back(exp);
        data_issued++;
        do begin
            @(negedge clk_core);
        end while (!data_gnt_o);
        check_flag("data_rvalid_o", 1'b1, data_rvalid_o);
        drive_slot();
        data_req_i = 1'b0;
    endtask

    // Both ports start in the same cycle from idle
    task automatic tie_round(input logic [ADDR_W-1:0] iaddr, input logic [ADDR_W-1:0] daddr,
                             input owner_e first, input owner_e second);
        order_q.delete();
        fork
            fetch(iaddr);
            data_access(1'b0, SEL_ALL, daddr, '0);
        join
        if (order_q.size() != 2) begin
            $display("Fail at %0t: tie round finished with %0d responses", $time, order_q.size());
            stop_on_failure();
        end
        check_owner("first grant", first, order_q[0]);
        check_owner("second grant", second, order_q[1]);
    endtask

    // Response monitor
    always @(negedge clk_core) begin
        expect_t data_exp;
        if (!rst_i) begin
            if (instr_rvalid_o) begin
                if (instr_exp_q.size() == 0) begin
                    $display("Fail at %0t: instruction response with no fetch open", $time);
                    stop_on_failure();
                end
                check_data("instr_rdata_o", instr_exp_q.pop_front(), instr_rdata_o);
                order_q.push_back(OWNER_INSTR);
                instr_done++;
            end
            if (data_rvalid_o) begin
                if (data_exp_q.size() == 0) begin
                    $display("Fail at %0t: data response with no request open", $time);
                    stop_on_failure();
                end
                data_exp = data_exp_q.pop_front();
                if (data_exp.is_read) begin
                    check_data("data_rdata_o", data_exp.word, data_rdata_o);
                end
                order_q.push_back(OWNER_DATA);
                data_done++;
            end
            if (mem_cyc_o) begin
                check_flag("mem_stb_o", 1'b1, mem_stb_o);
            end else begin
                check_flag("mem_stb_o", 1'b0, mem_stb_o);
            end
            if (mem_cyc_o && (mem_adr_o < DATA_BASE)) begin // Fetch owns the bus
                check_flag("mem_we_o", 1'b0, mem_we_o);
                check_sel("mem_sel_o", SEL_ALL, mem_sel_o);
            end
        end
    end

    always @(posedge clk_core) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with requests still waiting", cycle_cnt);
            stop_on_failure();
        end
    end

    initial begin
        rst_i          = 1'b1;
        instr_req_i    = 1'b0;
        instr_addr_i   = '0;
        data_req_i     = 1'b0;
        data_we_i      = 1'b0;
        data_be_i      = '0;
        data_addr_i    = '0;
        data_wdata_i   = '0;
        shadow_written = '{default: 1'b0};
        repeat (4) @(posedge clk_core);
        #1;
        rst_i = 1'b0;

        @(negedge clk_core);
        check_flag("instr_gnt_o", 1'b0, instr_gnt_o);
        check_flag("data_gnt_o", 1'b0, data_gnt_o);
        check_flag("instr_rvalid_o", 1'b0, instr_rvalid_o);
        check_flag("data_rvalid_o", 1'b0, data_rvalid_o);
        check_flag("mem_cyc_o", 1'b0, mem_cyc_o);
        drive_slot();

        // Single accesses in between flip who was served last
        last_served = OWNER_DATA;
        for (int t = 0; t < N_TIE; t++) begin
            if (t % 2 == 1) begin
                fetch(word_addr(100 + t));
                last_served = OWNER_INSTR;
            end else if (t > 0) begin
                data_access(1'b0, SEL_ALL, word_addr(200 + t), '0);
                last_served = OWNER_DATA;
            end
            winner = (last_served == OWNER_DATA) ? OWNER_INSTR : OWNER_DATA;
            tie_round(word_addr(t), word_addr(INSTR_WORDS + t), winner, last_served);
        end

        for (int w = 0; w < 4; w++) begin
            fetch(word_addr(16 + 7 * w));
        end

        // Partial writes merge into the old word
        data_access(1'b1, 4'b0101, word_addr(140), 32'hDEAD_BEEF);
        data_access(1'b0, SEL_ALL, word_addr(140), '0);
        data_access(1'b1, 4'b1000, word_addr(140), 32'h1234_5678);
        data_access(1'b0, SEL_ALL, word_addr(140), '0);

        fork
            begin
                int r_i;
                for (int n = 0; n < N_RAND_INSTR; n++) begin
                    r_i = $random(seed);
                    repeat (r_i & 3) drive_slot();
                    fetch(word_addr((r_i >>> 4) & 127));
                end
            end
            begin
                int r_d;
                for (int n = 0; n < N_RAND_DATA; n++) begin
                    r_d = $random(seed);
                    repeat (r_d & 3) drive_slot();
                    data_access(r_d[4], SEL_W'(r_d >>> 8),
                                word_addr(INSTR_WORDS + ((r_d >>> 12) & 15)),
                                DATA_W'($random(seed)));
                end
            end
        join

        if (instr_done != instr_issued || data_done != data_issued
            || instr_exp_q.size() != 0 || data_exp_q.size() != 0) begin
            $display("Fail at %0t: %0d of %0d fetches and %0d of %0d data requests completed",
                     $time, instr_done, instr_issued, data_done, data_issued);
            stop_on_failure();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* compile.f */
verilog/wb_harness_pkg.sv
verilog/wb_bus_if.sv
verilog/core_port_bridge.sv
verilog/wb_rr_arbiter.sv
verilog/mem_harness_top.sv
testbench/tb_wb_memory.sv
testbench/tb_mem_harness.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_mem_harness
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

# Build the simulation binary
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status comes from the search for the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
